// ==== conv_window_engine.f ====
+incdir+test
rtl/conv_geometry_pkg.sv
rtl/conv_data_pkg.sv
rtl/window_line_buffer.sv
rtl/window_position_tracker.sv
rtl/kernel_weight_store.sv
rtl/window_mac.sv
rtl/relu_output_stage.sv
rtl/conv_window_engine.sv
test/conv_window_engine_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f conv_window_engine.f \
	--top-module conv_window_engine_tb -o conv_window_engine_sim

out=$(./obj_dir/conv_window_engine_sim) || true
echo "$out"
if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// ==== test/conv_ref_model.svh ====
`ifndef CONV_REF_MODEL_SVH
`define CONV_REF_MODEL_SVH

// next state of the stimulus generator
function automatic int unsigned lcg_next(input int unsigned state);
	return state * 32'd1103515245 + 32'd12345;
endfunction

// one output pixel, window at (orow, ocol) dotted with the kernel, plus bias
function automatic int conv_expected(input int pix [0:PIXELS-1], input int coef [0:TAPS-1],
	input int b, input int orow, input int ocol);
	longint acc;
	acc = b;
	for (int r = 0; r < K; r++)
	begin
		for (int c = 0; c < K; c++)
		begin
			acc += longint'(pix[(orow + r) * IFM + ocol + c]) * coef[r * K + c];
		end
	end
	if (acc < 0)
		return 0;   // relu
	else if (acc > conv_data_pkg::OUT_MAX)
		return conv_data_pkg::OUT_MAX;
	return int'(acc);
endfunction

`endif

// ==== test/conv_window_engine_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_window_engine_tb;

	localparam int IFM = conv_geometry_pkg::IFM_SIZE_DEFAULT;
	localparam int K = conv_geometry_pkg::KERNEL_SIZE_DEFAULT;
	localparam int OUT_SIDE = conv_geometry_pkg::out_size(IFM, K);
	localparam int PIXELS = IFM * IFM;
	localparam int TAPS = K * K;
	localparam int AW = $clog2(TAPS + 1);
	localparam int MAX_GAP = 3;
	localparam int WATCHDOG_CYCLES = 9 * PIXELS * (1 + MAX_GAP) + 200;   // 9 frames

	logic clk;
	logic reset = 1'b1;
	logic pixel_valid = 1'b0;
	conv_data_pkg::pixel_t pixel_data = '0;
	logic wm_write = 1'b0;
	logic [AW-1:0] wm_addr = '0;
	conv_data_pkg::weight_t wm_data = '0;
	logic out_valid;
	conv_data_pkg::out_t out_data;

	int frame [0:PIXELS-1];
	int wts [0:TAPS-1];
	int bias_v;
	int exp_q [$];
	int unsigned lcg_state = 43193;
	int cycle = 0;
	int errors = 0;
	int errors_before = 0;
	int passed = 0;
	int failed = 0;
	int pix_seen;
	int accept_cycle;   // edge that took the first window closing pixel
	int first_out_cycle;
	int expected;

	`include "conv_ref_model.svh"

	conv_window_engine #(
		.IFM_SIZE(IFM),
		.KERNEL_SIZE(K)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_data(pixel_data),
		.wm_write(wm_write),
		.wm_addr(wm_addr),
		.wm_data(wm_data),
		.out_valid(out_valid),
		.out_data(out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	// ####################################################################
	// checker, sampled on the falling edge
	// ####################################################################

	always @(negedge clk)
	begin
		if (reset)
		begin
			pix_seen = 0;
			accept_cycle = -1;
			first_out_cycle = -1;
			if (out_valid)
			begin
				$display("out_valid high at %0d ns while reset is asserted", $time);
				errors++;
			end
		end
		else
		begin
			if (pixel_valid)
			begin
				if (pix_seen == (K - 1) * IFM + K - 1)
					accept_cycle = cycle + 1;   // taken on the coming edge
				pix_seen++;
			end
			if (out_valid && first_out_cycle < 0)
				first_out_cycle = cycle;
			if (out_valid && exp_q.size() == 0)
			begin
				$display("out_valid at %0d ns with no result expected", $time);
				errors++;
			end
			else if (out_valid)
			begin
				expected = exp_q.pop_front();
				if (out_data !== conv_data_pkg::out_t'(expected))
				begin
					$display("FAILED at %0d ns: out_data = %0d, expected %0d",
						$time, out_data, expected);
					errors++;
				end
			end
		end
	end

	function automatic int rand_between(input int lo, input int hi);
		int unsigned span;
		span = hi - lo + 1;
		lcg_state = lcg_next(lcg_state);
		return lo + int'((lcg_state >> 16) % span);
	endfunction

	task automatic fill_random(input int p_lo, input int p_hi, input int w_lo, input int w_hi,
		input int b_lo, input int b_hi);
		for (int i = 0; i < PIXELS; i++)
			frame[i] = rand_between(p_lo, p_hi);
		for (int i = 0; i < TAPS; i++)
			wts[i] = rand_between(w_lo, w_hi);
		bias_v = rand_between(b_lo, b_hi);
	endtask

	task automatic load_kernel();
		for (int i = 0; i <= TAPS; i++)
		begin
			@(posedge clk);
			wm_write <= 1'b1;
			wm_addr <= AW'(i);
			wm_data <= conv_data_pkg::weight_t'(i < TAPS ? wts[i] : bias_v);   // bias last
		end
		@(posedge clk);
		wm_write <= 1'b0;
	endtask

	task automatic stream_pixels(input int count, input int gap_max);
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			pixel_valid <= 1'b1;
			pixel_data <= conv_data_pkg::pixel_t'(frame[i]);
			repeat (rand_between(0, gap_max))
			begin
				@(posedge clk);
				pixel_valid <= 1'b0;
			end
		end
		@(posedge clk);
		pixel_valid <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clk);
		reset <= 1'b1;
		pixel_valid <= 1'b0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
	endtask

	// ####################################################################
	// one frame against the reference model
	// ####################################################################

	task automatic run_frame(input int gap_max);
		int waited;
		load_kernel();
		for (int r = 0; r < OUT_SIDE; r++)
		begin
			for (int c = 0; c < OUT_SIDE; c++)
				exp_q.push_back(conv_expected(frame, wts, bias_v, r, c));
		end
		stream_pixels(PIXELS, gap_max);
		waited = 0;
		while (exp_q.size() > 0 && waited < 20)
		begin
			@(posedge clk);
			waited++;
		end
		repeat (6) @(posedge clk);   // room for a stray extra pulse
	endtask

	task automatic finish_test(input string name);
		if (exp_q.size() != 0)
		begin
			$display("%s: %0d expected results never arrived", name, exp_q.size());
			errors++;
			exp_q.delete();
		end
		if (errors == errors_before)
			passed++;
		else
			failed++;
		$display("test %s: %s", name, (errors == errors_before) ? "ok" : "failed");
		errors_before = errors;
	endtask

	initial
	begin
		apply_reset();

		fill_random(-255, 255, -255, 255, -255, 255);
		run_frame(0);
		if (accept_cycle < 0 || first_out_cycle < 0)
		begin
			$display("no result came out for the first complete window");
			errors++;
		end
		else if (first_out_cycle - accept_cycle != 4)
		begin
			$display("FAILED at %0d ns: out_valid latency = %0d, expected 4",
				$time, first_out_cycle - accept_cycle);
			errors++;
		end
		finish_test("first_result_latency");

		fill_random(-255, 255, -255, 255, -255, 255);
		run_frame(0);
		finish_test("full_frame");

		fill_random(-255, 255, -255, 255, -255, 255);
		run_frame(MAX_GAP);
		finish_test("frame_with_gaps");

		// negative kernel on positive pixels, then full scale into the ceiling
		fill_random(1, 255, -255, -1, -255, 0);
		run_frame(0);
		fill_random(32000, 32767, 32000, 32767, 20000, 32767);
		run_frame(0);
		finish_test("relu_saturation");

		fill_random(-255, 255, -255, 255, -255, 255);
		run_frame(0);
		fill_random(-255, 255, -255, 255, -255, 255);
		run_frame(0);
		finish_test("back_to_back_reload");

		// two windows of the partial frame are still in flight when reset hits
		fill_random(-255, 255, -255, 255, -255, 255);
		load_kernel();
		stream_pixels((K - 1) * IFM + K + 1, 0);
		apply_reset();
		fill_random(-255, 255, -255, 255, -255, 255);
		run_frame(0);
		finish_test("reset_mid_frame");

		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
		if (failed == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/conv_window_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_window_engine #(
	parameter int IFM_SIZE = conv_geometry_pkg::IFM_SIZE_DEFAULT,
	parameter int KERNEL_SIZE = conv_geometry_pkg::KERNEL_SIZE_DEFAULT
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	input conv_data_pkg::pixel_t pixel_data,
	input wire logic wm_write,
	input wire logic [$clog2(KERNEL_SIZE*KERNEL_SIZE+1)-1:0] wm_addr,
	input conv_data_pkg::weight_t wm_data,
	output logic out_valid,
	output conv_data_pkg::out_t out_data
);

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

	conv_data_pkg::pixel_t window [0:TAPS-1];
	conv_data_pkg::weight_t weights [0:TAPS-1];
	conv_data_pkg::weight_t bias;
	conv_data_pkg::acc_t sum;
	logic window_valid;
	logic sum_valid;

	// ######################################################################
	// window generation, both blocks step on the same pixel strobe
	// ######################################################################

	window_line_buffer #(
		.IFM_SIZE(IFM_SIZE),
		.KERNEL_SIZE(KERNEL_SIZE)
	) line_buffer_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_data(pixel_data),
		.window(window)
	);

	window_position_tracker #(
		.IFM_SIZE(IFM_SIZE),
		.KERNEL_SIZE(KERNEL_SIZE)
	) tracker_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.window_valid(window_valid)
	);

	kernel_weight_store #(
		.KERNEL_SIZE(KERNEL_SIZE)
	) weight_store_i (
		.clk(clk),
		.reset(reset),
		.wm_write(wm_write),
		.wm_addr(wm_addr),
		.wm_data(wm_data),
		.weights(weights),
		.bias(bias)
	);

	// ######################################################################
	// arithmetic, 3 cycles of mac and 1 of output stage
	// ######################################################################

	window_mac #(
		.KERNEL_SIZE(KERNEL_SIZE)
	) mac_i (
		.clk(clk),
		.reset(reset),
		.window_valid(window_valid),
		.window(window),
		.weights(weights),
		.sum_valid(sum_valid),
		.sum(sum)
	);

	relu_output_stage output_stage_i (
		.clk(clk),
		.reset(reset),
		.sum_valid(sum_valid),
		.sum(sum),
		.bias(bias),
		.out_valid(out_valid),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

// ==== rtl/relu_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module relu_output_stage (
	input wire logic clk,
	input wire logic reset,
	input wire logic sum_valid,
	input conv_data_pkg::acc_t sum,
	input conv_data_pkg::weight_t bias,
	output logic out_valid,
	output conv_data_pkg::out_t out_data
);

	conv_data_pkg::acc_t biased;
	conv_data_pkg::out_t clamped;

	always_comb
	begin
		biased = sum + bias;   // bias sign extends in the wider context
		if (biased < 0)
			clamped = '0;   // relu
		else if (biased > conv_data_pkg::OUT_MAX)
			clamped = conv_data_pkg::OUT_WIDTH'(conv_data_pkg::OUT_MAX);
		else
			clamped = biased[conv_data_pkg::OUT_WIDTH-1:0];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= sum_valid;
	end

	always_ff @(posedge clk)
	begin
		if (sum_valid)
			out_data <= clamped;
	end

endmodule

`default_nettype wire

// ==== rtl/window_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_mac #(
	parameter int KERNEL_SIZE = 5
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic window_valid,
	input conv_data_pkg::pixel_t window [0:KERNEL_SIZE*KERNEL_SIZE-1],
	input conv_data_pkg::weight_t weights [0:KERNEL_SIZE*KERNEL_SIZE-1],
	output logic sum_valid,
	output conv_data_pkg::acc_t sum
);

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

	conv_data_pkg::acc_t prod [0:TAPS-1];           // stage 1
	conv_data_pkg::acc_t row_sum_d [0:KERNEL_SIZE-1];
	conv_data_pkg::acc_t row_sum [0:KERNEL_SIZE-1];  // stage 2
	conv_data_pkg::acc_t total_d;
	logic prod_valid;
	logic row_valid;

	// ######################################################################
	// valid bits alongside the three stages
	// ######################################################################

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prod_valid <= 1'b0;
			row_valid <= 1'b0;
			sum_valid <= 1'b0;
		end
		else
		begin
			prod_valid <= window_valid;
			row_valid <= prod_valid;
			sum_valid <= row_valid;
		end
	end

	// ######################################################################
	// datapath
	// ######################################################################

	// operands sign extend to the accumulator width before the multiply
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < TAPS; i++)
		begin
			prod[i] <= window[i] * weights[i];
		end
	end

	always_comb
	begin
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			row_sum_d[r] = '0;
			for (int c = 0; c < KERNEL_SIZE; c++)
			begin
				row_sum_d[r] = row_sum_d[r] + prod[r*KERNEL_SIZE+c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			row_sum[r] <= row_sum_d[r];
		end
	end

	always_comb
	begin
		total_d = '0;
		for (int r = 0; r < KERNEL_SIZE; r++)
		begin
			total_d = total_d + row_sum[r];
		end
	end

	always_ff @(posedge clk)
	begin
		sum <= total_d;   // stage 3
	end

	// window and its valid flag come from different upstream blocks
	for (genvar i = 0; i < TAPS; i++)
	begin : g_chk
		a_window_known: assert property (@(posedge clk) disable iff (reset)
			window_valid |-> !$isunknown(window[i]));
	end

endmodule

`default_nettype wire

// ==== rtl/kernel_weight_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module kernel_weight_store #(
	parameter int KERNEL_SIZE = 5
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic wm_write,
	input wire logic [$clog2(KERNEL_SIZE*KERNEL_SIZE+1)-1:0] wm_addr,
	input conv_data_pkg::weight_t wm_data,
	output conv_data_pkg::weight_t weights [0:KERNEL_SIZE*KERNEL_SIZE-1],
	output conv_data_pkg::weight_t bias
);

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;
	localparam int AW = $clog2(TAPS + 1);
	localparam logic [AW-1:0] BIAS_ADDR = AW'(TAPS);   // bias sits after the last weight

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < TAPS; i++)
			begin
				weights[i] <= '0;
			end
			bias <= '0;
		end
		else if (wm_write)
		begin
			for (int i = 0; i < TAPS; i++)
			begin
				if (wm_addr == AW'(i))
					weights[i] <= wm_data;
			end
			if (wm_addr == BIAS_ADDR)
				bias <= wm_data;
		end
	end

	a_addr_in_range: assert property (@(posedge clk) disable iff (reset)
		wm_write |-> wm_addr <= BIAS_ADDR);

endmodule

`default_nettype wire

// ==== rtl/window_position_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_position_tracker #(
	parameter int IFM_SIZE = 8,
	parameter int KERNEL_SIZE = 5
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	output logic window_valid
);

	localparam int CW = $clog2(IFM_SIZE);
	localparam logic [CW-1:0] LAST = CW'(IFM_SIZE - 1);
	localparam logic [CW-1:0] FIRST_FULL = CW'(KERNEL_SIZE - 1);

	logic [CW-1:0] col;   // position of the next pixel to arrive
	logic [CW-1:0] row;
	logic window_closes;

	// the incoming pixel is the bottom right corner of an in-map window
	assign window_closes = (col >= FIRST_FULL) && (row >= FIRST_FULL);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			col <= '0;
			row <= '0;
			window_valid <= 1'b0;
		end
		else
		begin
			window_valid <= pixel_valid && window_closes;
			if (pixel_valid)
			begin
				if (col == LAST)
				begin
					col <= '0;
					row <= (row == LAST) ? '0 : row + 1'b1;   // frame wrap
				end
				else
				begin
					col <= col + 1'b1;
				end
			end
		end
	end

	a_col_in_range: assert property (@(posedge clk) disable iff (reset)
		col <= LAST);

	// one pulse per accepted pixel, never stretched over an idle cycle
	a_valid_single: assert property (@(posedge clk) disable iff (reset)
		window_valid && !pixel_valid |=> !window_valid);

endmodule

`default_nettype wire

// ==== rtl/window_line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_line_buffer #(
	parameter int IFM_SIZE = 8,
	parameter int KERNEL_SIZE = 5
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic pixel_valid,
	input conv_data_pkg::pixel_t pixel_data,
	output conv_data_pkg::pixel_t window [0:KERNEL_SIZE*KERNEL_SIZE-1]
);

	localparam int DEPTH = conv_geometry_pkg::line_depth(IFM_SIZE, KERNEL_SIZE);

	conv_data_pkg::pixel_t chain [0:DEPTH-1];   // chain[0] holds the newest pixel

	// ######################################################################
	// shift chain, one step per accepted pixel
	// ######################################################################

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < DEPTH; i++)
			begin
				chain[i] <= '0;
			end
		end
		else if (pixel_valid)
		begin
			chain[0] <= pixel_data;
			for (int i = 1; i < DEPTH; i++)
			begin
				chain[i] <= chain[i-1];
			end
		end
	end

	// ######################################################################
	// window taps
	// ######################################################################

	// row 0 col 0 is the oldest tap, the last element is the newest pixel
	for (genvar r = 0; r < KERNEL_SIZE; r++)
	begin : g_row
		for (genvar c = 0; c < KERNEL_SIZE; c++)
		begin : g_col
			assign window[r*KERNEL_SIZE+c] =
				chain[(KERNEL_SIZE-1-r)*IFM_SIZE + (KERNEL_SIZE-1-c)];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/conv_data_pkg.sv ====
`default_nettype none

package conv_data_pkg;

	// ######################################################################
	// fixed point widths and datapath types
	// ######################################################################

	localparam int PIXEL_WIDTH = 16;
	localparam int WEIGHT_WIDTH = 16;
	localparam int ACC_WIDTH = 40;   // headroom for 25 full scale products
	localparam int OUT_WIDTH = 16;

	typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
	typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;   // also used for the bias
	typedef logic signed [ACC_WIDTH-1:0] acc_t;
	typedef logic [OUT_WIDTH-1:0] out_t;

	// saturation ceiling of the output stage
	localparam int OUT_MAX = 32767;

endpackage

`default_nettype wire

// ==== rtl/conv_geometry_pkg.sv ====
`default_nettype none

package conv_geometry_pkg;

	// ######################################################################
	// default feature map and kernel geometry
	// ######################################################################

	localparam int IFM_SIZE_DEFAULT = 8;     // map is square
	localparam int KERNEL_SIZE_DEFAULT = 5;

	// shift chain length needed to expose a full k x k window
	function automatic int line_depth(input int ifm, input int k);
		return (k - 1) * ifm + k;
	endfunction

	// side of the output map, stride 1 and no padding
	function automatic int out_size(input int ifm, input int k);
		return ifm - k + 1;
	endfunction

	localparam int LINE_DEPTH_DEFAULT = line_depth(IFM_SIZE_DEFAULT, KERNEL_SIZE_DEFAULT);
	localparam int OUT_SIZE_DEFAULT = out_size(IFM_SIZE_DEFAULT, KERNEL_SIZE_DEFAULT);
	localparam int FRAME_PIXELS_DEFAULT = IFM_SIZE_DEFAULT * IFM_SIZE_DEFAULT;
	localparam int FRAME_RESULTS_DEFAULT = OUT_SIZE_DEFAULT * OUT_SIZE_DEFAULT;

endpackage

`default_nettype wire
